/* files.f */
rtl/riscvPkg.sv
rtl/controlDecoder.sv
rtl/executeAlu.sv
rtl/branchCompare.sv
rtl/loadStoreAlign.sv
rtl/riscvCore.sv
rtl/registerFile.sv
rtl/riscvSystem.sv
verification/tbRiscvSystem.sv

/* rtl/branchCompare.sv */
module branchCompare (
	input logic [2:0] funct3,
	input logic [riscvPkg::XLEN-1:0] a,
	input logic [riscvPkg::XLEN-1:0] b,
	output logic taken
);

	always_comb begin
		case (funct3)
			3'b000: taken = (a == b); // beq
			3'b001: taken = (a != b); // bne
			3'b100: taken = $signed(a) < $signed(b);
			3'b101: taken = $signed(a) >= $signed(b);
			3'b110: taken = a < b; // bltu
			3'b111: taken = a >= b; // bgeu
			default: taken = 1'b0;
		endcase
	end

endmodule

/* rtl/controlDecoder.sv */
module controlDecoder (
	input logic [riscvPkg::XLEN-1:0] instr,
	output riscvPkg::ctrlT ctrl,
	output logic [riscvPkg::XLEN-1:0] imm,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic altOp; // instr[30], sub and sra select

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	// op-imm only honours bit 30 for shifts
	assign altOp = instr[30] & (opcode == riscvPkg::OPC_OP || funct3 == 3'b101);

	function automatic riscvPkg::aluOpE aluFromFunct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: aluFromFunct = alt ? riscvPkg::SUB : riscvPkg::ADD;
			3'b001: aluFromFunct = riscvPkg::SLL;
			3'b010: aluFromFunct = riscvPkg::SLT;
			3'b011: aluFromFunct = riscvPkg::SLTU;
			3'b100: aluFromFunct = riscvPkg::XOR;
			3'b101: aluFromFunct = alt ? riscvPkg::SRA : riscvPkg::SRL;
			3'b110: aluFromFunct = riscvPkg::OR;
			default: aluFromFunct = riscvPkg::AND;
		endcase
	endfunction

	always_comb begin
		ctrl = '0; // nop, writes nothing
		ctrl.funct3 = funct3;
		imm = {{20{instr[31]}}, instr[31:20]}; // I type unless overridden
		case (opcode)
			riscvPkg::OPC_LUI, riscvPkg::OPC_AUIPC: begin
				imm = {instr[31:12], 12'b0};
				ctrl.aluOp = (opcode == riscvPkg::OPC_LUI) ? riscvPkg::PASSB : riscvPkg::ADD;
				ctrl.srcAPc = (opcode == riscvPkg::OPC_AUIPC);
				ctrl.srcBImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			riscvPkg::OPC_JAL: begin
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
				ctrl.jump = 1'b1;
				ctrl.wbSel = riscvPkg::WB_PC4;
				ctrl.regWrite = 1'b1;
			end
			riscvPkg::OPC_JALR: begin
				ctrl.jalr = 1'b1;
				ctrl.srcBImm = 1'b1; // alu forms rs1 + imm
				ctrl.wbSel = riscvPkg::WB_PC4;
				ctrl.regWrite = 1'b1;
			end
			riscvPkg::OPC_BRANCH: begin
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
				ctrl.branch = 1'b1;
			end
			riscvPkg::OPC_LOAD: begin
				ctrl.srcBImm = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.wbSel = riscvPkg::WB_LOAD;
				ctrl.regWrite = 1'b1;
			end
			riscvPkg::OPC_STORE: begin
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
				ctrl.srcBImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			riscvPkg::OPC_OPIMM, riscvPkg::OPC_OP: begin
				ctrl.aluOp = aluFromFunct(funct3, altOp);
				ctrl.srcBImm = (opcode == riscvPkg::OPC_OPIMM);
				ctrl.regWrite = 1'b1;
			end
			riscvPkg::OPC_SYSTEM: ctrl.halt = (instr == riscvPkg::EBREAK_WORD);
			default: ;
		endcase
	end

endmodule

/* rtl/executeAlu.sv */
module executeAlu (
	input riscvPkg::aluOpE aluOp,
	input logic [riscvPkg::XLEN-1:0] a,
	input logic [riscvPkg::XLEN-1:0] b,
	output logic [riscvPkg::XLEN-1:0] result
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (aluOp)
			riscvPkg::ADD: result = a + b;
			riscvPkg::SUB: result = a - b;
			riscvPkg::SLL: result = a << shamt;
			riscvPkg::SLT: result = {31'b0, $signed(a) < $signed(b)};
			riscvPkg::SLTU: result = {31'b0, a < b};
			riscvPkg::XOR: result = a ^ b;
			riscvPkg::SRL: result = a >> shamt;
			riscvPkg::SRA: result = $signed(a) >>> shamt; // keeps sign bit
			riscvPkg::OR: result = a | b;
			riscvPkg::AND: result = a & b;
			riscvPkg::PASSB: result = b;
			default: result = '0;
		endcase
	end

endmodule

/* rtl/loadStoreAlign.sv */
module loadStoreAlign (
	input logic [2:0] funct3,
	input logic [1:0] byteOffset,
	input logic [riscvPkg::XLEN-1:0] storeData,
	output logic [3:0] byteEnable,
	output logic [riscvPkg::XLEN-1:0] alignedStore,
	input logic [riscvPkg::XLEN-1:0] readWord,
	output logic [riscvPkg::XLEN-1:0] loadValue
);

	logic [riscvPkg::XLEN-1:0] laneWord; // addressed lane moved down to bit 0
	logic unsignedLoad;

	assign laneWord = readWord >> {byteOffset, 3'b000};
	assign unsignedLoad = funct3[2];

	// store side, funct3[1:0] gives the size
	always_comb begin
		case (funct3[1:0])
			2'b00: begin
				alignedStore = {4{storeData[7:0]}};
				byteEnable = 4'b0001 << byteOffset;
			end
			2'b01: begin
				alignedStore = {2{storeData[15:0]}};
				byteEnable = byteOffset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				alignedStore = storeData;
				byteEnable = 4'b1111;
			end
		endcase
	end

	always_comb begin
		case (funct3[1:0])
			2'b00: loadValue = {{24{laneWord[7] & ~unsignedLoad}}, laneWord[7:0]};
			2'b01: loadValue = {{16{laneWord[15] & ~unsignedLoad}}, laneWord[15:0]};
			default: loadValue = readWord;
		endcase
	end

endmodule

/* rtl/registerFile.sv */
module registerFile (
	input logic CLK,
	input logic RSTn,
	input logic [4:0] ra1,
	input logic [4:0] ra2,
	input logic [4:0] wa,
	input logic we,
	input logic [riscvPkg::XLEN-1:0] wd,
	output logic [riscvPkg::XLEN-1:0] rd1,
	output logic [riscvPkg::XLEN-1:0] rd2
);

	logic [riscvPkg::XLEN-1:0] regs [32];

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	// x0 reads zero whatever is stored
	assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

/* rtl/riscvCore.sv */
module riscvCore (
	input logic CLK,
	input logic RSTn,
	output logic iMemCsn,
	output logic [riscvPkg::ADDR_WIDTH-1:0] iMemAddr,
	input logic [riscvPkg::XLEN-1:0] iMemData,
	output logic dMemCsn,
	output logic [riscvPkg::ADDR_WIDTH-1:0] dMemAddr,
	input logic [riscvPkg::XLEN-1:0] dMemRdata,
	output logic [riscvPkg::XLEN-1:0] dMemWdata,
	output logic dMemWen,
	output logic [3:0] dMemBe,
	output logic [4:0] rfRa1,
	output logic [4:0] rfRa2,
	output logic [4:0] rfWa,
	output logic rfWe,
	output logic [riscvPkg::XLEN-1:0] rfWd,
	input logic [riscvPkg::XLEN-1:0] rfRd1,
	input logic [riscvPkg::XLEN-1:0] rfRd2,
	output logic halt,
	output logic [31:0] numInst
);

	riscvPkg::ctrlT ctrl;
	logic [riscvPkg::XLEN-1:0] pc, pcNext, pcPlus4, branchTarget;
	logic [riscvPkg::XLEN-1:0] imm, opA, opB, aluResult, loadValue;
	logic taken;
	logic running; // low in reset and for the first cycle after release
	logic retire;

	controlDecoder decoder (.instr(iMemData), .ctrl(ctrl), .imm(imm),
		.rs1(rfRa1), .rs2(rfRa2), .rd(rfWa));

	executeAlu alu (.aluOp(ctrl.aluOp), .a(opA), .b(opB), .result(aluResult));

	branchCompare brCmp (.funct3(ctrl.funct3), .a(rfRd1), .b(rfRd2), .taken(taken));

	loadStoreAlign lsAlign (.funct3(ctrl.funct3), .byteOffset(aluResult[1:0]),
		.storeData(rfRd2), .byteEnable(dMemBe), .alignedStore(dMemWdata),
		.readWord(dMemRdata), .loadValue(loadValue));

	assign opA = ctrl.srcAPc ? pc : rfRd1;
	assign opB = ctrl.srcBImm ? imm : rfRd2;
	assign pcPlus4 = pc + 32'd4;
	assign branchTarget = pc + imm; // branches and jal

	always_comb begin
		if (ctrl.jalr)
			pcNext = {aluResult[riscvPkg::XLEN-1:1], 1'b0};
		else if (ctrl.jump || (ctrl.branch && taken))
			pcNext = branchTarget;
		else
			pcNext = pcPlus4;
	end

	always_comb begin
		case (ctrl.wbSel)
			riscvPkg::WB_LOAD: rfWd = loadValue;
			riscvPkg::WB_PC4: rfWd = pcPlus4;
			default: rfWd = aluResult;
		endcase
	end

	assign halt = ctrl.halt;
	assign retire = running & ~halt;
	assign rfWe = retire & ctrl.regWrite;

	assign iMemCsn = ~running;
	assign iMemAddr = pc[riscvPkg::ADDR_WIDTH-1:0];
	assign dMemCsn = ~(running & (ctrl.memRead | ctrl.memWrite));
	assign dMemAddr = aluResult[riscvPkg::ADDR_WIDTH+1:2]; // byte to word address
	assign dMemWen = ~(retire & ctrl.memWrite);

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= riscvPkg::RESET_PC;
			numInst <= '0;
			running <= 1'b0;
		end else begin
			running <= 1'b1;
			if (retire) begin
				pc <= pcNext;
				numInst <= numInst + 32'd1;
			end
		end
	end

endmodule

/* rtl/riscvPkg.sv */
package riscvPkg;

	localparam int XLEN = 32;
	localparam int ADDR_WIDTH = 12; // instr side byte address, data side word address
	localparam logic [XLEN-1:0] RESET_PC = '0;

	// major opcodes, instr[6:0]
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [XLEN-1:0] EBREAK_WORD = 32'h0010_0073;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND,
		PASSB // lui, result is operand b
	} aluOpE;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_LOAD,
		WB_PC4
	} wbSelE;

	typedef struct packed {
		aluOpE aluOp;
		logic srcAPc; // operand a from pc
		logic srcBImm; // operand b from immediate
		wbSelE wbSel;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic branch;
		logic jump; // jal
		logic jalr;
		logic [2:0] funct3;
		logic halt;
	} ctrlT;

endpackage

/* rtl/riscvSystem.sv */
module riscvSystem (
	input logic CLK,
	input logic RSTn,
	output logic iMemCsn,
	output logic [riscvPkg::ADDR_WIDTH-1:0] iMemAddr,
	input logic [riscvPkg::XLEN-1:0] iMemData,
	output logic dMemCsn,
	output logic [riscvPkg::ADDR_WIDTH-1:0] dMemAddr,
	input logic [riscvPkg::XLEN-1:0] dMemRdata,
	output logic [riscvPkg::XLEN-1:0] dMemWdata,
	output logic dMemWen,
	output logic [3:0] dMemBe,
	output logic halt,
	output logic [31:0] numInst,
	output logic [riscvPkg::XLEN-1:0] outputPort
);

	logic [4:0] rfRa1, rfRa2, rfWa;
	logic rfWe;
	logic [riscvPkg::XLEN-1:0] rfWd, rfRd1, rfRd2;

	riscvCore core (.CLK(CLK), .RSTn(RSTn),
		.iMemCsn(iMemCsn), .iMemAddr(iMemAddr), .iMemData(iMemData),
		.dMemCsn(dMemCsn), .dMemAddr(dMemAddr), .dMemRdata(dMemRdata),
		.dMemWdata(dMemWdata), .dMemWen(dMemWen), .dMemBe(dMemBe),
		.rfRa1(rfRa1), .rfRa2(rfRa2), .rfWa(rfWa), .rfWe(rfWe), .rfWd(rfWd),
		.rfRd1(rfRd1), .rfRd2(rfRd2), .halt(halt), .numInst(numInst));

	registerFile regs (.CLK(CLK), .RSTn(RSTn), .ra1(rfRa1), .ra2(rfRa2),
		.wa(rfWa), .we(rfWe), .wd(rfWd), .rd1(rfRd1), .rd2(rfRd2));

	assign outputPort = rfWd; // write-back value, every cycle

endmodule

/* runSim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Mdir obj_dir --top-module tbRiscvSystem -o tbRiscvSystem -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tbRiscvSystem > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
	exit 1
fi
exit 0

/* verification/tbRiscvSystem.sv */
module tbRiscvSystem;

	localparam int clkPeriod = 40;
	localparam int resetCycles = 8;
	localparam int runLimit = 300; // cycles per program run
	localparam int numRuns = 9; // eight program runs plus one spare for idle cycles
	localparam int watchdogTime = numRuns * (runLimit + resetCycles) * clkPeriod;

	logic CLK, RSTn;
	logic iMemCsn, dMemCsn, dMemWen, halt;
	logic [riscvPkg::ADDR_WIDTH-1:0] iMemAddr, dMemAddr;
	logic [riscvPkg::XLEN-1:0] iMemData, dMemRdata, dMemWdata, outputPort;
	logic [3:0] dMemBe;
	logic [31:0] numInst;
	logic [31:0] imem [1024] = '{default: '0};
	logic [31:0] dmem [4096] = '{default: '0};
	logic [31:0] rngState = 32'd19;
	int progLen = 0;
	int errors = 0;

	riscvSystem dut (.CLK(CLK), .RSTn(RSTn),
		.iMemCsn(iMemCsn), .iMemAddr(iMemAddr), .iMemData(iMemData),
		.dMemCsn(dMemCsn), .dMemAddr(dMemAddr), .dMemRdata(dMemRdata),
		.dMemWdata(dMemWdata), .dMemWen(dMemWen), .dMemBe(dMemBe),
		.halt(halt), .numInst(numInst), .outputPort(outputPort));

	assign iMemData = imem[iMemAddr[riscvPkg::ADDR_WIDTH-1:2]]; // word indexed
	assign dMemRdata = dmem[dMemAddr];

	function automatic logic [31:0] fillWord(input int addr);
		return addr * 32'h9E37_79B9 + 32'h1357_9BDF;
	endfunction

	// data memory refills with its pattern while reset is held
	always @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < 4096; i++)
				dmem[i] <= fillWord(i);
		end else if (!dMemWen) begin
			for (int b = 0; b < 4; b++)
				if (dMemBe[b])
					dmem[dMemAddr][8*b +: 8] <= dMemWdata[8*b +: 8];
		end
	end

	initial begin
		CLK = 1'b0;
		forever #(clkPeriod / 2) CLK = ~CLK;
	end

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic logic [31:0] encR(input int f7, rs2, rs1, f3, rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], riscvPkg::OPC_OP};
	endfunction

	function automatic logic [31:0] encI(input int imm, rs1, f3, rd, input logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic logic [31:0] encS(input int imm, rs2, rs1, f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], riscvPkg::OPC_STORE};
	endfunction

	function automatic logic [31:0] encB(input int imm, rs2, rs1, f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			riscvPkg::OPC_BRANCH};
	endfunction

	function automatic logic [31:0] encU(input int imm, rd, input logic [6:0] op);
		return {imm[19:0], rd[4:0], op};
	endfunction

	function automatic logic [31:0] encJ(input int imm, rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], riscvPkg::OPC_JAL};
	endfunction

	// op packs funct7 bit 5 above funct3
	function automatic logic [31:0] aluRef(input logic [3:0] op, input logic [31:0] a, b);
		logic [31:0] r;
		logic [4:0] sh;
		sh = b[4:0];
		case (op[2:0])
			3'd0: r = op[3] ? a - b : a + b;
			3'd1: r = a << sh;
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (op[3])
					r = $signed(a) >>> sh;
				else
					r = a >> sh;
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected, actual);
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic emit(input logic [31:0] word);
		imem[progLen] = word;
		progLen++;
	endtask

	task automatic loadConst(input int rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = (value + 32'h800) >> 12; // addi sign-extends the low 12 bits
		emit(encU(upper, rd, riscvPkg::OPC_LUI));
		emit(encI(value, rd, 0, rd, riscvPkg::OPC_OPIMM));
	endtask

	task automatic beginProgram();
		@(negedge CLK);
		RSTn = 1'b1;
		@(negedge CLK); // old program goes quiet after one reset edge
		for (int i = 0; i < 1024; i++)
			imem[i] = '0;
		progLen = 0;
	endtask

	task automatic runProgram(input string name);
		int cycles = 0;
		repeat (resetCycles - 1) @(negedge CLK);
		RSTn = 1'b0;
		while (!halt && cycles < runLimit) begin
			@(negedge CLK);
			cycles++;
		end
		if (!halt) begin
			errors++;
			$display("%s: core did not halt within %0d cycles", name, runLimit);
		end
	endtask

	task automatic aluTest(input string name, input logic [31:0] a, b,
		input logic [39:0] ops, input int nOps);
		logic [3:0] op;
		beginProgram();
		loadConst(1, a);
		loadConst(2, b);
		emit(encS(0, 1, 0, 2));
		for (int i = 0; i < nOps; i++) begin
			op = ops[4*i +: 4];
			emit(encR(op[3] ? 32 : 0, 2, 1, int'(op[2:0]), 4));
			emit(encS(4 * (i + 1), 4, 0, 2));
		end
		emit(riscvPkg::EBREAK_WORD);
		runProgram(name);
		checkValue(name, a, dmem[0]);
		for (int i = 0; i < nOps; i++)
			checkValue(name, aluRef(ops[4*i +: 4], a, b), dmem[i + 1]);
		checkValue(name, 5 + 2 * nOps, numInst);
	endtask

	task automatic branchLoop();
		int trips = 7;
		beginProgram();
		emit(encI(trips, 0, 0, 1, riscvPkg::OPC_OPIMM));
		emit(encI(100, 0, 0, 6, riscvPkg::OPC_OPIMM));
		emit(encI(0, 0, 0, 5, riscvPkg::OPC_OPIMM));
		emit(encI(3, 5, 0, 5, riscvPkg::OPC_OPIMM)); // loop top at 12
		emit(encI(-1, 1, 0, 1, riscvPkg::OPC_OPIMM));
		emit(encB(8, 6, 1, 5)); // bge never taken
		emit(encB(-12, 0, 1, 1)); // bne back to 12
		emit(encB(8, 5, 1, 4)); // taken blt skips the clear
		emit(encI(0, 0, 0, 5, riscvPkg::OPC_OPIMM));
		emit(encS(0, 5, 0, 2));
		emit(encS(4, 1, 0, 2));
		emit(riscvPkg::EBREAK_WORD);
		runProgram("branchLoop");
		checkValue("branchLoop", 3 * trips, dmem[0]);
		checkValue("branchLoop", 0, dmem[1]);
		checkValue("branchLoop", 6 + 4 * trips, numInst); // setup and tail plus four per trip
	endtask

	task automatic byteAccess();
		int offs [6] = '{8, 9, 10, 10, 8, 11};
		int f3s [6] = '{0, 4, 0, 1, 5, 0}; // lb lbu lb lh lhu lb
		logic [31:0] loadExp [6] = '{32'hFFFF_FF9A, 32'h0000_00E0, 32'h0000_007F,
			32'hFFFF_8C7F, 32'h0000_E09A, 32'hFFFF_FF8C};
		beginProgram();
		loadConst(1, 32'h1234_56C3);
		loadConst(8, 32'h8C7F_E09A);
		emit(encS(8, 8, 0, 2));
		for (int k = 0; k < 4; k++)
			emit(encS(16 + 5 * k, 1, 0, 0)); // sb into lane k of word 4+k
		emit(encS(32, 1, 0, 1));
		emit(encS(38, 1, 0, 1));
		for (int i = 0; i < 6; i++)
			emit(encI(offs[i], 0, f3s[i], i + 2, riscvPkg::OPC_LOAD));
		for (int i = 0; i < 6; i++)
			emit(encS(48 + 4 * i, i + 2, 0, 2));
		emit(riscvPkg::EBREAK_WORD);
		runProgram("byteAccess");
		for (int k = 0; k < 4; k++)
			checkValue("byteAccess", (fillWord(4 + k) & ~(32'hFF << (8 * k))) |
				(32'hC3 << (8 * k)), dmem[4 + k]);
		checkValue("byteAccess", (fillWord(8) & 32'hFFFF_0000) | 32'h0000_56C3, dmem[8]);
		checkValue("byteAccess", (fillWord(9) & 32'h0000_FFFF) | 32'h56C3_0000, dmem[9]);
		for (int i = 0; i < 6; i++)
			checkValue("byteAccess", loadExp[i], dmem[12 + i]);
		checkValue("byteAccess", 23, numInst);
	endtask

	task automatic jumpProgram();
		emit(encU(32'hABCDE, 1, riscvPkg::OPC_LUI));
		emit(encU(32'h12, 2, riscvPkg::OPC_AUIPC)); // at 4
		emit(encJ(12, 3)); // jal from 8 to 20
		emit(encI(1, 0, 0, 9, riscvPkg::OPC_OPIMM));
		emit(encI(2, 0, 0, 9, riscvPkg::OPC_OPIMM));
		emit(encI(37, 0, 0, 4, riscvPkg::OPC_OPIMM)); // odd target loses bit 0
		emit(encI(0, 4, 0, 5, riscvPkg::OPC_JALR)); // jalr from 24 to 36
		emit(encI(3, 0, 0, 9, riscvPkg::OPC_OPIMM));
		emit(encI(4, 0, 0, 9, riscvPkg::OPC_OPIMM));
		emit(encS(0, 1, 0, 2));
		emit(encS(4, 2, 0, 2));
		emit(encS(8, 3, 0, 2));
		emit(encS(12, 5, 0, 2));
		emit(encS(16, 9, 0, 2)); // x9 stays zero if the skips hold
		emit(riscvPkg::EBREAK_WORD);
	endtask

	task automatic checkJumps(input string name);
		checkValue(name, 32'hABCD_E000, dmem[0]);
		checkValue(name, 32'd4 + (32'h12 << 12), dmem[1]);
		checkValue(name, 32'd8 + 32'd4, dmem[2]);
		checkValue(name, 32'd24 + 32'd4, dmem[3]);
		checkValue(name, 32'd0, dmem[4]);
		checkValue(name, 32'd10, numInst);
	endtask

	task automatic resetHalt();
		beginProgram();
		jumpProgram();
		emit(encS(16, 1, 0, 2)); // past the ebreak, would overwrite word 4
		runProgram("resetHalt");
		repeat (20) @(negedge CLK);
		checkJumps("resetHalt"); // nothing moves while halted
		// rerun and cut it short after three retired instructions
		RSTn = 1'b1;
		repeat (resetCycles) @(negedge CLK);
		RSTn = 1'b0;
		repeat (4) @(negedge CLK);
		checkValue("resetHalt", 3, numInst);
		checkValue("resetHalt", 32'd37, outputPort); // write data of the addi at 20
		RSTn = 1'b1;
		@(negedge CLK);
		checkValue("resetHalt", 0, numInst);
		checkValue("resetHalt", 32'd1, {31'b0, iMemCsn});
		checkValue("resetHalt", 32'd1, {31'b0, dMemCsn});
		runProgram("resetHalt");
		checkJumps("resetHalt");
	endtask

	initial begin
		#(watchdogTime);
		$display("watchdog expired before the tests finished");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		logic [31:0] ra, rb;
		RSTn = 1'b1;
		aluTest("aluBasic", 32'hFFFF_FB2E, 32'd777, 40'h76_D543_2180, 10);
		branchLoop();
		byteAccess();
		beginProgram();
		jumpProgram();
		runProgram("jumps");
		checkJumps("jumps");
		resetHalt();
		for (int r = 0; r < 2; r++) begin
			ra = nextRandom();
			rb = nextRandom();
			aluTest("randomOps", ra, rb, 40'h00_000D_3480, 5); // add sub xor sltu sra
		end
		$display("tests done, %0d errors", errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
